/* zx_bus_pkg.sv */
// port bus definitions for the input subsystem
// wishbone request/response structs and the spectrum port map

package zx_bus_pkg;

	// cpu side port address and data
	typedef logic [15:0] port_addr_t;
	typedef logic [7:0] port_data_t;

	// wishbone classic request, host to slave
	typedef struct packed
	{
		logic cyc;
		logic stb;
		logic we;
		port_addr_t adr;
		port_data_t dat; // write data, ignored by these ports
	} wb_req_t;

	// wishbone classic response, slave to host
	typedef struct packed
	{
		logic ack;
		port_data_t dat;
	} wb_rsp_t;

	// low address byte of each port
	// a real spectrum maps every even port to the keyboard, only FE here
	localparam port_data_t kbd_port_lo = 8'hFE;
	localparam port_data_t mus_port_lo = 8'hDF; // kempston mouse, high byte picks the register
	localparam port_data_t joy_port_lo = 8'h1F; // kempston joystick

	// floating bus value
	localparam port_data_t idle_data = 8'hFF;

endpackage

/* zx_input_pkg.sv */
// input side definitions
// spi frame commands, load targets and key matrix sizes

package zx_input_pkg;

	// key matrix, 8 half-rows of 5 keys
	localparam int kbd_bits  = 40;
	localparam int kbd_rows  = 8;
	localparam int kbd_cols  = 5;
	localparam int kbd_bytes = kbd_bits / 8; // data bytes in a keyboard frame

	typedef logic [kbd_cols-1:0] key_row_t; // answer of the matrix, active low

	// first byte of a frame from the controller
	typedef enum logic [7:0]
	{
		cmd_kbd     = 8'h01, // 5 data bytes
		cmd_mus_x   = 8'h02, // 1 data byte
		cmd_mus_y   = 8'h03, // 1 data byte
		cmd_mus_btn = 8'h04, // 1 data byte
		cmd_joy     = 8'h05  // 1 data byte
	} spi_cmd_e;

	// which register a completed frame writes
	typedef enum logic [2:0]
	{
		ld_kbd,
		ld_mus_x,
		ld_mus_y,
		ld_mus_btn,
		ld_joy
	} load_target_e;

	// load request from the frame decoder
	typedef struct packed
	{
		logic valid; // one cycle pulse
		load_target_e target;
		logic [kbd_bits-1:0] data; // single byte commands use bits 7:0
	} input_load_t;

endpackage

/* spi_byte_rx.sv */
// spi mode 0 byte receiver
// pins are synchronized into fclk, bytes assembled msb first

module spi_byte_rx
(
	input  logic fclk,
	input  logic rst_n,
	input  logic sclk,
	input  logic mosi,
	input  logic cs_n,
	output zx_bus_pkg::port_data_t rx_byte,
	output logic rx_valid,
	output logic frame_active
);

	logic [1:0] sclk_sync;
	logic [1:0] mosi_sync;
	logic [1:0] cs_sync;
	logic sclk_d; // previous synced sclk
	logic sclk_rise;
	logic [2:0] bit_cnt;
	logic [7:0] shift;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sclk_sync <= 2'b00;
			mosi_sync <= 2'b00;
			cs_sync   <= 2'b11; // deselected
			sclk_d    <= 1'b0;
		end
		else
		begin
			sclk_sync <= {sclk_sync[0], sclk};
			mosi_sync <= {mosi_sync[0], mosi};
			cs_sync   <= {cs_sync[0], cs_n};
			sclk_d    <= sclk_sync[1];
		end
	end

	assign sclk_rise = sclk_sync[1] & ~sclk_d;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			bit_cnt  <= 3'd0;
			rx_valid <= 1'b0;
		end
		else
		begin
			rx_valid <= 1'b0;
			if (cs_sync[1])
				bit_cnt <= 3'd0; // realign on every frame
			else if (sclk_rise)
			begin
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7)
					rx_valid <= 1'b1;
			end
		end
	end

	// data path, mosi sampled with the same sync delay as sclk
	always_ff @(posedge fclk)
	begin
		if (sclk_rise)
		begin
			shift <= {shift[6:0], mosi_sync[1]};
			if (bit_cnt == 3'd7)
				rx_byte <= {shift[6:0], mosi_sync[1]};
		end
	end

	assign frame_active = ~cs_sync[1];

endmodule

/* input_cmd_decoder.sv */
// spi frame decoder
// first byte selects the target, data bytes are collected into one load

module input_cmd_decoder
(
	input  logic fclk,
	input  logic rst_n,
	input  zx_bus_pkg::port_data_t rx_byte,
	input  logic rx_valid,
	input  logic frame_active,
	output zx_input_pkg::input_load_t load
);

	typedef enum logic [1:0]
	{
		wait_cmd,
		collect,
		skip
	} state_e;

	state_e state;
	zx_input_pkg::load_target_e tgt;
	logic [2:0] last_idx;  // index of the final data byte
	logic [2:0] idx;       // current data byte
	logic ld_valid;
	logic [zx_input_pkg::kbd_bits-1:0] shadow;

	// command decode
	zx_input_pkg::load_target_e cmd_tgt;
	logic [2:0] cmd_last;
	logic cmd_known;

	always_comb
	begin
		cmd_tgt   = zx_input_pkg::ld_kbd;
		cmd_last  = 3'd0;
		cmd_known = 1'b1;
		case (zx_input_pkg::spi_cmd_e'(rx_byte))
			zx_input_pkg::cmd_kbd:
			begin
				cmd_tgt  = zx_input_pkg::ld_kbd;
				cmd_last = 3'(zx_input_pkg::kbd_bytes - 1);
			end
			zx_input_pkg::cmd_mus_x:   cmd_tgt = zx_input_pkg::ld_mus_x;
			zx_input_pkg::cmd_mus_y:   cmd_tgt = zx_input_pkg::ld_mus_y;
			zx_input_pkg::cmd_mus_btn: cmd_tgt = zx_input_pkg::ld_mus_btn;
			zx_input_pkg::cmd_joy:     cmd_tgt = zx_input_pkg::ld_joy;
			default:                   cmd_known = 1'b0;
		endcase
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= wait_cmd;
			tgt      <= zx_input_pkg::ld_kbd;
			last_idx <= 3'd0;
			idx      <= 3'd0;
			ld_valid <= 1'b0;
		end
		else
		begin
			ld_valid <= 1'b0;
			if (!frame_active)
				state <= wait_cmd; // partial frame is dropped here
			else if (rx_valid)
			begin
				case (state)
					wait_cmd:
					begin
						tgt      <= cmd_tgt;
						last_idx <= cmd_last;
						idx      <= 3'd0;
						state    <= cmd_known ? collect : skip;
					end
					collect:
					begin
						idx <= idx + 3'd1;
						if (idx == last_idx)
						begin
							ld_valid <= 1'b1;
							state    <= skip; // trailing bytes ignored
						end
					end
					default: ;
				endcase
			end
		end
	end

	// byte i lands in bits 8i+7:8i
	always_ff @(posedge fclk)
	begin
		if (frame_active && rx_valid && state == collect)
			shadow[{idx, 3'b000} +: 8] <= rx_byte;
	end

	assign load = '{valid: ld_valid, target: tgt, data: shadow};

endmodule

/* zx_input_regs.sv */
// keyboard, mouse and joystick state
// forms the key matrix answer and the kempston mouse byte for the port bus

module zx_input_regs
(
	input  logic fclk,
	input  logic rst_n,
	input  zx_input_pkg::input_load_t load,
	input  logic [7:0] zah,
	output zx_input_pkg::key_row_t kbd_row,
	output zx_bus_pkg::port_data_t mus_byte,
	output logic [4:0] joy_bits
);

	logic [zx_input_pkg::kbd_bits-1:0] kbd; // 1 = key pressed
	zx_bus_pkg::port_data_t mus_x;
	zx_bus_pkg::port_data_t mus_y;
	zx_bus_pkg::port_data_t mus_btn;
	zx_input_pkg::key_row_t kout;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			kbd      <= '0;
			mus_x    <= '0;
			mus_y    <= '0;
			mus_btn  <= '0;
			joy_bits <= '0;
		end
		else if (load.valid)
		begin
			case (load.target)
				zx_input_pkg::ld_kbd:     kbd      <= load.data;
				zx_input_pkg::ld_mus_x:   mus_x    <= load.data[7:0];
				zx_input_pkg::ld_mus_y:   mus_y    <= load.data[7:0];
				zx_input_pkg::ld_mus_btn: mus_btn  <= load.data[7:0];
				zx_input_pkg::ld_joy:     joy_bits <= load.data[4:0];
				default: ;
			endcase
		end
	end

	// wired-and over all selected half-rows
	// column j of row r is key bit r+8j, output bit 4-j
	always_comb
	begin
		kout = '1;
		for (int r = 0; r < zx_input_pkg::kbd_rows; r++)
		begin
			for (int j = 0; j < zx_input_pkg::kbd_cols; j++)
			begin
				if (!zah[r] && kbd[r + 8*j])
					kout[zx_input_pkg::kbd_cols-1-j] = 1'b0;
			end
		end
	end

	assign kbd_row = kout;

	// FADF buttons, FBDF x, FFDF y
	assign mus_byte = zah[0] ? (zah[2] ? mus_y : mus_x) : mus_btn;

endmodule

/* zx_port_wb.sv */
// wishbone classic slave for the input ports
// decodes the low address byte, ack and read data registered

module zx_port_wb
(
	input  logic fclk,
	input  logic rst_n,
	input  zx_bus_pkg::wb_req_t wb_req,
	output zx_bus_pkg::wb_rsp_t wb_rsp,
	output logic [7:0] zah,
	input  zx_input_pkg::key_row_t kbd_row,
	input  zx_bus_pkg::port_data_t mus_byte,
	input  logic [4:0] joy_bits
);

	logic req;
	logic served; // request seen last cycle, blocks a second ack
	logic ack_q;
	zx_bus_pkg::port_data_t dat_q;
	zx_bus_pkg::port_data_t rd_data;

	assign req = wb_req.cyc & wb_req.stb;
	assign zah = wb_req.adr[15:8];

	always_comb
	begin
		case (wb_req.adr[7:0])
			zx_bus_pkg::kbd_port_lo: rd_data = {3'b111, kbd_row};
			zx_bus_pkg::mus_port_lo: rd_data = mus_byte;
			zx_bus_pkg::joy_port_lo: rd_data = {3'b000, joy_bits};
			default:                 rd_data = zx_bus_pkg::idle_data;
		endcase
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ack_q  <= 1'b0;
			served <= 1'b0;
		end
		else
		begin
			ack_q  <= req & ~served;
			served <= req; // clears once stb drops
		end
	end

	// writes only get the ack
	always_ff @(posedge fclk)
	begin
		if (req && !served && !wb_req.we)
			dat_q <= rd_data;
	end

	assign wb_rsp = '{ack: ack_q, dat: dat_q};

endmodule

/* zx_input_top.sv */
// input subsystem top
// spi receiver, frame decoder, state registers and port bus slave

module zx_input_top
(
	input  logic fclk,
	input  logic rst_n,
	input  logic sclk,
	input  logic mosi,
	input  logic cs_n,
	input  zx_bus_pkg::wb_req_t wb_req,
	output zx_bus_pkg::wb_rsp_t wb_rsp
);

	zx_bus_pkg::port_data_t rx_byte;
	logic rx_valid;
	logic frame_active;
	zx_input_pkg::input_load_t load;
	logic [7:0] zah;
	zx_input_pkg::key_row_t kbd_row;
	zx_bus_pkg::port_data_t mus_byte;
	logic [4:0] joy_bits;

	spi_byte_rx u_rx (.fclk(fclk), .rst_n(rst_n), .sclk(sclk), .mosi(mosi), .cs_n(cs_n),
		.rx_byte(rx_byte), .rx_valid(rx_valid), .frame_active(frame_active));

	input_cmd_decoder u_dec (.fclk(fclk), .rst_n(rst_n), .rx_byte(rx_byte),
		.rx_valid(rx_valid), .frame_active(frame_active), .load(load));

	zx_input_regs u_regs (.fclk(fclk), .rst_n(rst_n), .load(load), .zah(zah),
		.kbd_row(kbd_row), .mus_byte(mus_byte), .joy_bits(joy_bits));

	zx_port_wb u_wb (.fclk(fclk), .rst_n(rst_n), .wb_req(wb_req), .wb_rsp(wb_rsp),
		.zah(zah), .kbd_row(kbd_row), .mus_byte(mus_byte), .joy_bits(joy_bits));

endmodule

/* tb_zx_input.sv */
// testbench for the input subsystem
// drives spi frames and checks the wishbone port reads against the port map rules

module tb_zx_input;

	localparam int wd_limit = 6 * 20 * 6 * 8 * 160 + 100000;

	logic fclk;
	logic rst_n;
	logic sclk;
	logic mosi;
	logic cs_n;
	zx_bus_pkg::wb_req_t wb_req;
	zx_bus_pkg::wb_rsp_t wb_rsp;

	zx_bus_pkg::port_data_t tx_buf [0:4]; // data bytes of the next frame
	logic [39:0] kbd_model;
	zx_bus_pkg::port_data_t mx_model;
	zx_bus_pkg::port_data_t my_model;
	zx_bus_pkg::port_data_t mb_model;
	zx_bus_pkg::port_data_t joy_model;
	integer seed = 46;
	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;

	zx_input_top uut (.fclk(fclk), .rst_n(rst_n), .sclk(sclk), .mosi(mosi), .cs_n(cs_n),
		.wb_req(wb_req), .wb_rsp(wb_rsp));

	initial
	begin
		fclk = 1'b0;
		forever #10 fclk = ~fclk;
	end

	initial
	begin
		#(wd_limit);
		$display("timeout: the tests did not finish within %0d time units", wd_limit);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// per column j the selected half-rows are kbd bits 8j+7:8j
	function automatic zx_bus_pkg::port_data_t expect_kbd(input logic [39:0] keys,
		input logic [7:0] hi);
		zx_bus_pkg::port_data_t v;
		v = 8'hFF;
		for (int j = 0; j < 5; j++)
			v[4 - j] = ~|(~hi & keys[8*j +: 8]);
		return v;
	endfunction

	task automatic check_port_data(input zx_bus_pkg::port_data_t got,
		input zx_bus_pkg::port_data_t exp, input string msg);
		if (got !== exp)
		begin
			$display("mismatch at %0t: %s read %h, expected %h", $time, msg, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_ack(input logic acked, input int cycles, input logic ack_after,
		input string msg);
		if (!acked || cycles > 2)
		begin
			$display("error at %0t: %s was not acknowledged within 2 cycles", $time, msg);
			test_errors++;
		end
		else if (ack_after)
		begin
			$display("error at %0t: %s was acknowledged more than once", $time, msg);
			test_errors++;
		end
	endtask

	task automatic wb_access(input logic we, input zx_bus_pkg::port_addr_t addr,
		input zx_bus_pkg::port_data_t wdat, output zx_bus_pkg::port_data_t rdat);
		int n;
		logic acked;
		n = 0;
		acked = 1'b0;
		@(posedge fclk);
		wb_req.cyc <= 1'b1;
		wb_req.stb <= 1'b1;
		wb_req.we  <= we;
		wb_req.adr <= addr;
		wb_req.dat <= wdat;
		while (!acked && n < 8)
		begin
			@(posedge fclk);
			n++;
			acked = wb_rsp.ack;
		end
		rdat = wb_rsp.dat;
		wb_req <= '0;
		@(posedge fclk); // ack must be gone by now
		check_ack(acked, n, wb_rsp.ack, $sformatf("access to port %h", addr));
	endtask

	task automatic wb_read(input zx_bus_pkg::port_addr_t addr,
		output zx_bus_pkg::port_data_t rdat);
		wb_access(1'b0, addr, 8'h00, rdat);
	endtask

	task automatic wb_write(input zx_bus_pkg::port_addr_t addr, input zx_bus_pkg::port_data_t d);
		zx_bus_pkg::port_data_t unused;
		wb_access(1'b1, addr, d, unused);
	endtask

	task automatic read_check(input zx_bus_pkg::port_addr_t addr,
		input zx_bus_pkg::port_data_t exp);
		zx_bus_pkg::port_data_t d;
		wb_read(addr, d);
		check_port_data(d, exp, $sformatf("port %h", addr));
	endtask

	task automatic settle();
		repeat (8) @(posedge fclk);
	endtask

	// mode 0 byte with msb first and 8 fclk per sclk period
	task automatic spi_byte(input zx_bus_pkg::port_data_t b);
		for (int i = 7; i >= 0; i--)
		begin
			@(posedge fclk);
			sclk <= 1'b0;
			mosi <= b[i];
			repeat (4) @(posedge fclk);
			sclk <= 1'b1;
			repeat (3) @(posedge fclk);
		end
	endtask

	// fewer data bytes than the command needs gives an aborted frame
	task automatic spi_frame(input zx_bus_pkg::port_data_t cmd, input int n_data);
		@(posedge fclk);
		cs_n <= 1'b0;
		repeat (4) @(posedge fclk);
		spi_byte(cmd);
		for (int i = 0; i < n_data; i++)
			spi_byte(tx_buf[i]);
		@(posedge fclk);
		sclk <= 1'b0;
		repeat (4) @(posedge fclk);
		cs_n <= 1'b1;
		settle();
	endtask

	task automatic start_test();
		test_errors = 0;
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		errors += test_errors;
		$display("test %0d %s: %s", tests_run, name, (test_errors == 0) ? "ok" : "failed");
	endtask

	task automatic reset_values();
		start_test();
		read_check(16'h00FE, 8'hFF);
		read_check(16'h7FFE, 8'hFF);
		read_check(16'hFEFE, 8'hFF);
		read_check(16'hFADF, 8'h00);
		read_check(16'hFBDF, 8'h00);
		read_check(16'hFFDF, 8'h00);
		read_check(16'h001F, 8'h00);
		report_test("reset values");
	endtask

	task automatic keyboard_matrix();
		logic [63:0] r;
		logic [7:0] hi;
		start_test();
		r = {$random(seed), $random(seed)};
		kbd_model = r[39:0];
		for (int i = 0; i < 5; i++)
			tx_buf[i] = kbd_model[8*i +: 8]; // byte i is bits 8i+7:8i
		spi_frame(zx_input_pkg::cmd_kbd, 5);
		read_check(16'h00FE, expect_kbd(kbd_model, 8'h00));
		for (int row = 0; row < 8; row++)
		begin
			hi = ~(8'h01 << row);
			read_check({hi, 8'hFE}, expect_kbd(kbd_model, hi));
		end
		read_check(16'h5AFE, expect_kbd(kbd_model, 8'h5A));
		read_check(16'hC3FE, expect_kbd(kbd_model, 8'hC3));
		report_test("keyboard matrix");
	endtask

	task automatic mouse_bytes();
		start_test();
		mx_model = $random(seed);
		my_model = $random(seed);
		mb_model = $random(seed);
		tx_buf[0] = mx_model;
		spi_frame(zx_input_pkg::cmd_mus_x, 1);
		tx_buf[0] = my_model;
		spi_frame(zx_input_pkg::cmd_mus_y, 1);
		tx_buf[0] = mb_model;
		spi_frame(zx_input_pkg::cmd_mus_btn, 1);
		read_check(16'hFADF, mb_model);
		read_check(16'hFBDF, mx_model);
		read_check(16'hFFDF, my_model);
		report_test("mouse bytes");
	endtask

	task automatic joystick_bits();
		start_test();
		joy_model = $random(seed);
		tx_buf[0] = joy_model;
		spi_frame(zx_input_pkg::cmd_joy, 1);
		read_check(16'h001F, {3'b000, joy_model[4:0]});
		report_test("joystick bits");
	endtask

	task automatic ignored_frames();
		logic [7:0] hi;
		start_test();
		for (int i = 0; i < 5; i++)
			tx_buf[i] = $random(seed);
		// a joystick command hidden in the data would load if it were decoded
		tx_buf[1] = zx_input_pkg::cmd_joy;
		tx_buf[2] = ~joy_model;
		spi_frame(zx_input_pkg::cmd_kbd, 3); // cs_n rises early
		spi_frame(8'h09, 5);
		mx_model = tx_buf[0]; // only the first byte of the next frame counts
		spi_frame(zx_input_pkg::cmd_mus_x, 3);
		read_check(16'h00FE, expect_kbd(kbd_model, 8'h00));
		for (int row = 0; row < 8; row++)
		begin
			hi = ~(8'h01 << row);
			read_check({hi, 8'hFE}, expect_kbd(kbd_model, hi));
		end
		read_check(16'hFADF, mb_model);
		read_check(16'hFBDF, mx_model);
		read_check(16'hFFDF, my_model);
		read_check(16'h001F, {3'b000, joy_model[4:0]});
		report_test("ignored frames");
	endtask

	task automatic unmapped_and_write();
		start_test();
		read_check(16'h00FD, 8'hFF);
		wb_write(16'h00FE, 8'h00);
		read_check(16'h00FE, expect_kbd(kbd_model, 8'h00));
		report_test("unmapped port and write");
	endtask

	initial
	begin
		rst_n = 1'b0;
		sclk = 1'b0;
		mosi = 1'b0;
		cs_n = 1'b1;
		wb_req = '0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (10) @(posedge fclk);
		rst_n <= 1'b1;
		repeat (2) @(posedge fclk);
		reset_values();
		keyboard_matrix();
		mouse_bytes();
		joystick_bits();
		ignored_frames();
		unmapped_and_write();
		$display("tests run %0d, tests failed %0d, check errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* tb.f */
zx_bus_pkg.sv
zx_input_pkg.sv
spi_byte_rx.sv
input_cmd_decoder.sv
zx_input_regs.sv
zx_port_wb.sv
zx_input_top.sv
tb_zx_input.sv
